/* Bender.yml */
package:
  name: router_output_port

sources:
  - files:
      - hw/nocFlitPkg.sv
      - hw/arbStatePkg.sv
      - hw/portLinkIf.sv
      - hw/portQuantumTimer.sv
      - hw/switchArbiter.sv
      - hw/grantDataMux.sv
      - hw/routerOutputPort.sv
  - target: test
    files:
      - testbench/tbRouterOutputPort.sv

/* hw/arbStatePkg.sv */
`default_nettype none

package arbStatePkg;
  import nocFlitPkg::*;

  ////////////////////////////////////////////////////////////
  // grant state encoding
  ////////////////////////////////////////////////////////////

  // bit 0 is idle, bit p+1 means port p holds the output.
  typedef logic [NumPorts:0] grantStateT;

  localparam grantStateT StateIdle = grantStateT'(1);

  // one-hot state for a granted port.
  function automatic grantStateT portState(input portDirT port);
    grantStateT st;
    st = '0;
    st[int'(port) + 1] = 1'b1;
    return st;
  endfunction

  // port reached after stepping forward in cyclic order.
  function automatic portDirT rotatePort(input portDirT port, input int unsigned step);
    int unsigned idx;
    idx = (int'(port) + step) % NumPorts;
    return portDirT'(idx);
  endfunction

endpackage

`default_nettype wire

/* hw/grantDataMux.sv */
`timescale 1ns/100ps
`default_nettype none

module grantDataMux
  import nocFlitPkg::*;
#(
  parameter int DataWidth = 32
)
(
  input  wire logic [NumPorts-1:0] grant,
  portLinkIf.muxSide               links [NumPorts],
  output logic [DataWidth-1:0]     outData,
  output logic                     outValid
);

  logic [DataWidth-1:0] portData [NumPorts];

  for (genvar p = 0; p < NumPorts; p++)
  begin : gData
    assign portData[p] = links[p].data;
  end

  ////////////////////////////////////////////////////////////
  // and-or select
  ////////////////////////////////////////////////////////////

  // safe only because the grant is one-hot or zero.
  always_comb
  begin
    outData = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      outData = outData | (portData[p] & {DataWidth{grant[p]}});
    end
  end

  assign outValid = |grant;                     // any owner means valid data.

  // grant comes from the arbiter state register.
  grantOneHot: assert final ($isunknown(grant) || $onehot0(grant))
    else $error("grantDataMux: grant %b selects several ports", grant);

endmodule

`default_nettype wire

/* hw/nocFlitPkg.sv */
`default_nettype none

package nocFlitPkg;

  ////////////////////////////////////////////////////////////
  // router geometry
  ////////////////////////////////////////////////////////////

  localparam int NumPorts = 5;                  // local plus four mesh links.

  // port index order also fixes the idle priority.
  typedef enum logic [2:0]
  {
    PortLocal = 3'd0,
    PortNorth = 3'd1,
    PortEast  = 3'd2,
    PortWest  = 3'd3,
    PortSouth = 3'd4
  } portDirT;

  ////////////////////////////////////////////////////////////
  // flit fields
  ////////////////////////////////////////////////////////////

  localparam int FlitIdWidth = 3;
  localparam int LengthWidth = 12;              // also the quantum counter width.

  // identifier codes.
  localparam logic [FlitIdWidth-1:0] FlitIdHeader = 3'd1;  // carries packet length.

  // other codes (body, tail) pass through untouched.
  // only the header affects switch allocation.

endpackage

`default_nettype wire

/* hw/portLinkIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface portLinkIf
  import nocFlitPkg::*;
#(
  parameter int DataWidth = 32
)
();

  logic                   req;                 // port wants the output.
  logic [FlitIdWidth-1:0] flitId;
  logic [LengthWidth-1:0] length;
  logic [DataWidth-1:0]   data;
  logic                   runTimer;            // holder keeps grant this cycle.
  logic                   timesUp;             // quantum used up.

  modport timerSide
  (
    input  flitId,
    input  length,
    input  runTimer,
    output timesUp
  );

  modport arbSide
  (
    input  req,
    input  timesUp,
    output runTimer
  );

  modport muxSide
  (
    input  data
  );

endinterface

`default_nettype wire

/* hw/portQuantumTimer.sv */
`timescale 1ns/100ps
`default_nettype none

module portQuantumTimer
  import nocFlitPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  portLinkIf.timerSide  link
);

  logic [LengthWidth-1:0] quantum;
  logic [LengthWidth-1:0] count;

  ////////////////////////////////////////////////////////////
  // quantum latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quantum <= '0;
    end
    else if (link.flitId == FlitIdHeader)
    begin
      quantum <= link.length;                   // header carries the packet length.
    end
  end

  ////////////////////////////////////////////////////////////
  // occupancy counter
  ////////////////////////////////////////////////////////////

  // counts only the cycles the arbiter lets this port keep the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!link.runTimer)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  assign link.timesUp = (count == quantum);

  // arbiter must drop runTimer once the quantum is reached.
  countInQuantum: assert property (
    @(posedge clk) disable iff (rst) link.runTimer |-> (count <= quantum)
  )
    else $error("portQuantumTimer: count %0d beyond quantum %0d", count, quantum);

endmodule

`default_nettype wire

/* hw/routerOutputPort.sv */
`timescale 1ns/100ps
`default_nettype none

module routerOutputPort
  import nocFlitPkg::*;
#(
  parameter int DataWidth = 32
)
(
  input  wire logic                                  clk,
  input  wire logic                                  rst,
  input  wire logic [NumPorts-1:0]                   req,
  input  wire logic [NumPorts-1:0][FlitIdWidth-1:0]  flitId,
  input  wire logic [NumPorts-1:0][LengthWidth-1:0]  length,
  input  wire logic [NumPorts-1:0][DataWidth-1:0]    data,
  output logic [NumPorts-1:0]                        grant,
  output logic [DataWidth-1:0]                       outData,
  output logic                                       outValid
);

  portLinkIf #(.DataWidth(DataWidth)) links [NumPorts] ();

  ////////////////////////////////////////////////////////////
  // input ports and quantum timers
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    assign links[p].req    = req[p];
    assign links[p].flitId = flitId[p];
    assign links[p].length = length[p];
    assign links[p].data   = data[p];

    portQuantumTimer portQuantumTimerInst
    (
      .clk  (clk),
      .rst  (rst),
      .link (links[p])
    );
  end

  ////////////////////////////////////////////////////////////
  // allocation and output
  ////////////////////////////////////////////////////////////

  switchArbiter switchArbiterInst
  (
    .clk   (clk),
    .rst   (rst),
    .links (links),
    .grant (grant)
  );

  // grant is registered, so data lags the request by one cycle.
  grantDataMux
  #(
    .DataWidth (DataWidth)
  )
  grantDataMuxInst
  (
    .grant    (grant),
    .links    (links),
    .outData  (outData),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

/* hw/switchArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module switchArbiter
  import nocFlitPkg::*;
  import arbStatePkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  portLinkIf.arbSide     links [NumPorts],
  output logic [NumPorts-1:0] grant
);

  grantStateT          state;
  grantStateT          nextState;
  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;
  portDirT             holder;
  logic                holding;

  ////////////////////////////////////////////////////////////
  // per-port link signals
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++)
  begin : gLink
    assign req[p]            = links[p].req;
    assign timesUp[p]        = links[p].timesUp;
    assign links[p].runTimer = runTimer[p];
  end

  // which port owns the output right now.
  always_comb
  begin
    holder = PortLocal;                         // idle search starts here.
    for (int p = 0; p < NumPorts; p++)
    begin
      if (state[p + 1])
      begin
        holder = portDirT'(p);
      end
    end
  end

  assign holding = |state[NumPorts:1];

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  // idle searches from local inclusive, a holder from the port after it.
  always_comb
  begin
    int firstStep;
    nextState = StateIdle;
    runTimer  = '0;
    firstStep = state[0] ? 0 : 1;
    if (holding && req[holder] && !timesUp[holder])
    begin
      nextState        = state;                 // keep the grant.
      runTimer[holder] = 1'b1;
    end
    else
    begin
      // walk backwards so the nearest requester wins.
      for (int step = NumPorts - 1; step >= 0; step--)
      begin
        if (step >= firstStep && req[rotatePort(holder, step)])
        begin
          nextState = portState(rotatePort(holder, step));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= StateIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[NumPorts:1];             // drop the idle bit.

  // the registered state must never hold two owners or none.
  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("switchArbiter: state %b not one-hot", state);

  // only the holder may advance its quantum timer.
  singleRunTimer: assert property (@(posedge clk) disable iff (rst) $onehot0(runTimer))
    else $error("switchArbiter: runTimer %b has several bits set", runTimer);

endmodule

`default_nettype wire

/* src.f */
hw/nocFlitPkg.sv
hw/arbStatePkg.sv
hw/portLinkIf.sv
hw/portQuantumTimer.sv
hw/switchArbiter.sv
hw/grantDataMux.sv
hw/routerOutputPort.sv
testbench/tbRouterOutputPort.sv

/* testbench/arbiterInput.txt */
# columns: req mask, header-flit mask, length, expected grant (all hex, one vector per cycle)
# the expected grant is checked one clock after its vector is driven
00 00 000 00
00 09 003 00
03 00 000 01
03 00 000 01
03 00 000 01
03 00 000 01
03 00 000 02
03 00 000 01
1f 00 000 01
1e 00 000 02
1e 00 000 04
1e 00 000 08
1e 00 000 08
02 00 000 02
00 00 000 00
00 00 000 00
11 00 000 01
10 00 000 10
11 00 000 01
00 00 000 00

/* testbench/tbRouterOutputPort.sv */
`timescale 1ns/100ps
`default_nettype none

module tbRouterOutputPort
  import nocFlitPkg::*;
();

  localparam int DataWidth    = 32;
  localparam int NumVectors   = 20;
  localparam int MaxLines     = 200;             // guards against a runaway file.
  localparam int ResetTimeout = 20;

  localparam logic [FlitIdWidth-1:0] FlitIdBody = 3'd2;

  logic                                 clk;
  logic                                 rst;
  logic [NumPorts-1:0]                  req;
  logic [NumPorts-1:0][FlitIdWidth-1:0] flitId;
  logic [NumPorts-1:0][LengthWidth-1:0] length;
  logic [NumPorts-1:0][DataWidth-1:0]   data;
  logic [NumPorts-1:0]                  grant;
  logic [DataWidth-1:0]                 outData;
  logic                                 outValid;

  routerOutputPort #(.DataWidth(DataWidth)) routerOutputPort_inst
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .data     (data),
    .grant    (grant),
    .outData  (outData),
    .outValid (outValid)
  );

  ////////////////////////////////////////////////////////////
  // clock and reset
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  initial
  begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;                                  // released between edges.
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // fixed payload per port, distinct in every nibble.
  function automatic logic [DataWidth-1:0] portData(input int p);
    return 32'h1111_1111 * (p + 1);
  endfunction

  // payload of the single granted port, zero while idle.
  function automatic logic [DataWidth-1:0] expectedOutData(input logic [NumPorts-1:0] grantV);
    logic [DataWidth-1:0] result;
    result = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grantV == (NumPorts'(1) << p))
      begin
        result = portData(p);
      end
    end
    return result;
  endfunction

  task automatic stopRun();
    $display("Some tests failed");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic checkHex(input string name, input logic [DataWidth-1:0] expV,
                          input logic [DataWidth-1:0] actV, input int lineNo);
    assert (actV === expV)
    else
    begin
      $display("CHECK FAILED %s at vector %0d: expected %h, got %h", name, lineNo, expV, actV);
      stopRun();
    end
  endtask

  task automatic checkOutputs(input logic [NumPorts-1:0] expGrant, input int lineNo);
    checkHex("grant", DataWidth'(expGrant), DataWidth'(grant), lineNo);
    checkHex("outData", expectedOutData(expGrant), outData, lineNo);
    checkHex("outValid", DataWidth'(|expGrant), DataWidth'(outValid), lineNo);
  endtask

  task automatic driveVector(input logic [NumPorts-1:0] reqV, input logic [NumPorts-1:0] hdrV,
                             input logic [LengthWidth-1:0] lenV);
    for (int p = 0; p < NumPorts; p++)
    begin
      req[p]    = reqV[p];
      flitId[p] = hdrV[p] ? FlitIdHeader : FlitIdBody;
      length[p] = lenV;
      data[p]   = portData(p);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // vector loop
  ////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          code;
    int          lineNo;
    int          resetWait;
    string       lineStr;
    logic [31:0] reqV;
    logic [31:0] hdrV;
    logic [31:0] lenV;
    logic [31:0] expV;
    driveVector('0, '0, '0);
    fd = $fopen("testbench/arbiterInput.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the vector file testbench/arbiterInput.txt");
      stopRun();
    end
    resetWait = 0;
    do
    begin
      @(posedge clk);
      resetWait++;
    end
    while (rst !== 1'b0 && resetWait < ResetTimeout);
    if (rst !== 1'b0)
    begin
      $display("reset was not released within %0d cycles", ResetTimeout);
      stopRun();
    end
    @(negedge clk);
    checkOutputs('0, 0);                         // idle after reset.
    lineNo = 0;
    while (!$feof(fd) && lineNo < MaxLines)
    begin
      code = $fgets(lineStr, fd);
      if (code > 1 && lineStr[0] != "#")
      begin
        code = $sscanf(lineStr, "%h %h %h %h", reqV, hdrV, lenV, expV);
        if (code != 4)
        begin
          $display("vector line after vector %0d could not be parsed", lineNo);
          stopRun();
        end
        lineNo++;
        driveVector(reqV[NumPorts-1:0], hdrV[NumPorts-1:0], lenV[LengthWidth-1:0]);
        @(negedge clk);
        checkOutputs(expV[NumPorts-1:0], lineNo);  // grant registered at the edge between.
      end
    end
    $fclose(fd);
    if (lineNo != NumVectors)
    begin
      $display("vector file ended early after %0d of %0d vectors", lineNo, NumVectors);
      stopRun();
    end
    else
    begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
